/* uart_pkg.sv */
package uart_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // line level types
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [7:0] uart_byte_t;    // one byte on the wire
  typedef logic [3:0] bit_idx_t;      // 0..10 within a frame

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  // result of one received frame
  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;   // parity bit did not match the data
    logic       stop_err;     // stop bit sampled low
  } rx_status_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~

  // even parity: the bit that makes the total count of ones even
  function automatic logic even_parity(input uart_byte_t b);
    logic p;
    p = ^b;
    return p;
  endfunction

endpackage

/* cmd_pkg.sv */
package cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // host command types
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [15:0] cmd_word_t;    // raw word from the host
  typedef logic [6:0]  reg_addr_t;    // remote register address
  typedef logic [7:0]  reg_data_t;    // remote register contents

  // field view of cmd_word_t
  //   [15]   1 = write, 0 = read
  //   [14:8] register address
  //   [7:0]  write data, ignored on reads
  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t data;
  } cmd_fields_t;

endpackage

/* uart_tx_frame.sv */
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int BIT_CYCLES = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);

  localparam int CNT_W = $clog2(BIT_CYCLES);

  logic [CNT_W-1:0]                 cnt;       // clocks within the current bit
  uart_pkg::bit_idx_t               bit_idx;   // bit currently on the line
  logic [uart_pkg::FRAME_BITS-1:0]  frame;     // bits still to go, lsb next
  logic                             bit_end;

  assign bit_end = tx_busy && (cnt == CNT_W'(BIT_CYCLES - 1));

  // ~~~~~~~~~~~~~~~~~~~~
  // frame shift register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (tx_start)
      frame <= {1'b1, uart_pkg::even_parity(tx_byte), tx_byte, 1'b0};
    else if (bit_end)
      frame <= {1'b1, frame[uart_pkg::FRAME_BITS-1:1]};  // fill with idle level
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // bit timing and line
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else if (tx_start)
    begin
      tx      <= 1'b0;                        // start bit
      tx_busy <= 1'b1;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else if (bit_end)
    begin
      cnt <= '0;
      if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1))
      begin
        tx      <= 1'b1;                      // stop bit done, back to idle
        tx_busy <= 1'b0;
      end
      else
      begin
        tx      <= frame[1];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else if (tx_busy)
      cnt <= cnt + 1'b1;
  end

  // the controller must wait for the line to go idle before a new byte
  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
  );

endmodule

/* uart_rx_frame.sv */
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int BIT_CYCLES = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_done,
  output uart_pkg::rx_status_t rx_stat
);

  localparam int CNT_W     = $clog2(BIT_CYCLES);
  localparam int SAMPLES   = uart_pkg::FRAME_BITS - 1;   // data, parity, stop

  typedef enum logic [1:0] {
    rs_idle,
    rs_start,
    rs_bits
  } rx_state_t;

  rx_state_t          state;
  logic               rx_meta;
  logic               rx_sync;
  logic               rx_prev;
  logic               fall;
  logic [CNT_W-1:0]   cnt;
  uart_pkg::bit_idx_t bit_idx;
  logic [SAMPLES-1:0] samp;
  logic [SAMPLES-1:0] samp_next;
  logic               half_bit;
  logic               full_bit;

  assign fall      = rx_prev && !rx_sync;
  assign half_bit  = (cnt == CNT_W'(BIT_CYCLES / 2 - 1));
  assign full_bit  = (cnt == CNT_W'(BIT_CYCLES - 1));
  assign samp_next = {rx_sync, samp[SAMPLES-1:1]};       // newest bit enters at msb

  // ~~~~~~~~~~~~~~~~~~~~
  // input synchronizer
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // frame sampling
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= rs_idle;
      cnt     <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        rs_idle:
        begin
          cnt <= '0;
          if (fall)
            state <= rs_start;
        end
        rs_start:
        begin
          if (half_bit)
          begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? rs_idle : rs_bits;  // glitch, not a start bit
          end
        end
        default:
        begin
          if (full_bit)
          begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == uart_pkg::bit_idx_t'(SAMPLES - 1))
            begin
              rx_done <= 1'b1;                  // center of stop bit
              state   <= rs_idle;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == rs_bits && full_bit)
    begin
      samp <= samp_next;
      if (bit_idx == uart_pkg::bit_idx_t'(SAMPLES - 1))
      begin
        rx_stat.data       <= samp_next[7:0];
        rx_stat.parity_err <= uart_pkg::even_parity(samp_next[7:0]) != samp_next[8];
        rx_stat.stop_err   <= !samp_next[9];
      end
    end
  end

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) rx_done |=> !rx_done
  );

endmodule

/* uart_cmd_ctrl.sv */
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int BIT_CYCLES        = 434,
  parameter int GAP_BITS          = 2,
  parameter int RESP_TIMEOUT_BITS = 40
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::cmd_word_t   cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output uart_pkg::uart_byte_t tx_byte,
  input  logic                 tx_busy,
  input  logic                 rx_done,
  input  uart_pkg::rx_status_t rx_stat,
  output logic                 read_rdy,
  output cmd_pkg::reg_data_t   read_data,
  output logic                 read_err
);

  localparam int GAP_CYCLES     = GAP_BITS * BIT_CYCLES;
  localparam int TIMEOUT_CYCLES = RESP_TIMEOUT_BITS * BIT_CYCLES;
  localparam int MAX_CYCLES     = (GAP_CYCLES > TIMEOUT_CYCLES) ? GAP_CYCLES : TIMEOUT_CYCLES;
  localparam int CNT_W          = $clog2(MAX_CYCLES + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_send_cmd,
    st_wait_cmd,
    st_gap,
    st_send_data,
    st_wait_data,
    st_wait_resp,
    st_done_read
  } ctrl_state_t;

  ctrl_state_t          state;
  ctrl_state_t          state_nxt;
  cmd_pkg::cmd_fields_t cmd_q;
  logic [CNT_W-1:0]     cnt;        // gap and response timeout share this
  logic                 gap_end;
  logic                 timeout;

  assign cmd_rdy  = (state == st_idle);
  assign tx_start = (state == st_send_cmd) || (state == st_send_data);
  assign tx_byte  = (state == st_send_data) ? cmd_q.data : {cmd_q.write, cmd_q.addr};
  assign read_rdy = (state == st_done_read);
  assign gap_end  = (cnt == CNT_W'(GAP_CYCLES - 1));
  assign timeout  = (cnt == CNT_W'(TIMEOUT_CYCLES - 1));

  // ~~~~~~~~~~~~~~~~~~~~
  // sequencing
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:      if (cmd_vld) state_nxt = st_send_cmd;
      st_send_cmd:  state_nxt = st_wait_cmd;
      st_wait_cmd:  if (!tx_busy) state_nxt = cmd_q.write ? st_gap : st_wait_resp;
      st_gap:       if (gap_end) state_nxt = st_send_data;
      st_send_data: state_nxt = st_wait_data;
      st_wait_data: if (!tx_busy) state_nxt = st_idle;
      st_wait_resp: if (rx_done || timeout) state_nxt = st_done_read;
      default:      state_nxt = st_idle;                  // done_read lasts one cycle
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
      cnt   <= '0;
    end
    else
    begin
      state <= state_nxt;
      if ((state == st_gap || state == st_wait_resp) && state_nxt == state)
        cnt <= cnt + 1'b1;
      else
        cnt <= '0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // command and result
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_pkg::cmd_fields_t'(cmd_in);
    if (state == st_wait_resp && rx_done)
    begin
      read_data <= rx_stat.data;
      read_err  <= rx_stat.parity_err || rx_stat.stop_err;
    end
    else if (state == st_wait_resp && timeout)
    begin
      read_data <= '0;                                    // no answer from the device
      read_err  <= 1'b1;
    end
  end

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  );

  // a new byte only goes to an idle transmitter, which then takes it
  a_start_handshake: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy ##1 tx_busy
  );

endmodule

/* uart_cmd_master.sv */
`timescale 1ns/1ps

module uart_cmd_master #(
  parameter int BIT_CYCLES        = 434,
  parameter int GAP_BITS          = 2,
  parameter int RESP_TIMEOUT_BITS = 40
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cmd_pkg::cmd_word_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  input  logic               rx,
  output logic               tx,
  output logic               read_rdy,
  output cmd_pkg::reg_data_t read_data,
  output logic               read_err
);

  logic                 tx_start;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_busy;
  logic                 rx_done;
  uart_pkg::rx_status_t rx_stat;

  uart_cmd_ctrl #(
    .BIT_CYCLES        (BIT_CYCLES),
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) uart_cmd_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_stat   (rx_stat),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .BIT_CYCLES (BIT_CYCLES)
  ) uart_tx_frame_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx_frame #(
    .BIT_CYCLES (BIT_CYCLES)
  ) uart_rx_frame_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_stat (rx_stat)
  );

endmodule

/* uart_slave_model.sv */
`timescale 1ns/1ps

module uart_slave_model #(
  parameter int BIT_CYCLES = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 line_in,       // from master tx
  output logic                 line_out,      // to master rx
  input  logic                 silent,
  input  logic                 bad_parity,
  output uart_pkg::uart_byte_t last_cmd,
  output uart_pkg::uart_byte_t last_data,
  output logic                 par_err_seen,
  output int                   frame_cnt
);

  uart_pkg::uart_byte_t regs [128];
  logic                 have_cmd;            // data byte of a write comes next

  task automatic wait_bits(input int n);
    repeat (n * BIT_CYCLES) @(posedge clk);
  endtask

  // starts on the start edge and samples each bit at its centre
  task automatic get_frame(output uart_pkg::uart_byte_t b, output logic par,
                           output logic stop);
    repeat (BIT_CYCLES / 2) @(posedge clk);
    for (int i = 0; i < 8; i++)
    begin
      wait_bits(1);
      b[i] = line_in;
    end
    wait_bits(1);
    par = line_in;
    wait_bits(1);
    stop = line_in;
  endtask

  task automatic put_frame(input uart_pkg::uart_byte_t b, input logic flip);
    logic [10:0] f;
    f = {1'b1, (^b) ^ flip, b, 1'b0};        // stop, parity, data, start
    for (int i = 0; i < 10; i++)
    begin
      line_out = f[i];
      repeat (BIT_CYCLES) @(posedge clk);
      #1;
    end
    line_out = f[10];                         // stop level runs on into the idle line
  endtask

  initial
  begin
    line_out     = 1'b1;
    last_cmd     = '0;
    last_data    = '0;
    par_err_seen = 1'b0;
    frame_cnt    = 0;
    have_cmd     = 1'b0;
    for (int a = 0; a < 128; a++)
      regs[a] = 8'(a) ^ 8'hA5;                // power-up contents
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // frame decode
  // ~~~~~~~~~~~~~~~~~~~~

  always
  begin : decode
    uart_pkg::uart_byte_t b;
    logic                 par;
    logic                 stop;
    wait (rst_n === 1'b1);
    @(negedge line_in);
    get_frame(b, par, stop);
    frame_cnt++;
    if (par !== (^b))
      par_err_seen = 1'b1;
    if (have_cmd)
    begin
      last_data            = b;
      regs[last_cmd[6:0]]  = b;
      have_cmd             = 1'b0;
    end
    else
    begin
      last_cmd = b;
      if (b[7])
        have_cmd = 1'b1;
      else if (!silent)
      begin
        wait_bits(3);                         // turnaround before the reply
        #1;
        put_frame(regs[b[6:0]], bad_parity);
      end
    end
  end

endmodule

/* tb_uart_cmd_master.sv */
`timescale 1ns/1ps

module tb_uart_cmd_master;

  localparam int BIT_CYCLES = 16;
  localparam int MAX_CYCLES = 120000;         // ~60 commands x 40 bits x 16 clocks + margin

  logic                 clk;
  logic                 rst_n;
  cmd_pkg::cmd_word_t   cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  logic                 read_rdy;
  cmd_pkg::reg_data_t   read_data;
  logic                 read_err;
  logic                 silent;
  logic                 bad_parity;
  uart_pkg::uart_byte_t slv_cmd;
  uart_pkg::uart_byte_t slv_data;
  logic                 slv_par_err;
  int                   slv_frames;
  cmd_pkg::reg_data_t   shadow [128];
  int                   errors;
  int                   tests;
  int                   failed;
  int                   cycles;

  uart_cmd_master #(
    .BIT_CYCLES (BIT_CYCLES)
  ) uart_cmd_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_slave_model #(
    .BIT_CYCLES (BIT_CYCLES)
  ) uart_slave_model_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .line_in      (tx),
    .line_out     (rx),
    .silent       (silent),
    .bad_parity   (bad_parity),
    .last_cmd     (slv_cmd),
    .last_data    (slv_data),
    .par_err_seen (slv_par_err),
    .frame_cnt    (slv_frames)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // reference and checks
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic cmd_pkg::reg_data_t expected_read(input cmd_pkg::reg_addr_t addr,
                                                       input logic no_reply);
    if (no_reply)
      return '0;
    return shadow[addr];
  endfunction

  task automatic check_data(input string name, input cmd_pkg::reg_data_t got,
                            input cmd_pkg::reg_data_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                            input uart_pkg::uart_byte_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      failed++;
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // host side
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    while (cmd_rdy !== 1'b1)
      step();
  endtask

  task automatic issue_cmd(input cmd_pkg::cmd_word_t w);
    wait_idle();
    cmd_in  = w;
    cmd_vld = 1'b1;
    step();                                   // taken at this edge
    cmd_vld = 1'b0;
  endtask

  // returns in the cycle of the read_rdy pulse
  task automatic wait_read(output cmd_pkg::reg_data_t d, output logic e);
    while (read_rdy !== 1'b1)
      step();
    d = read_data;
    e = read_err;
  endtask

  initial
  begin : stimulus
    cmd_pkg::reg_data_t d;
    logic               e;
    cmd_pkg::reg_addr_t a;
    cmd_pkg::cmd_word_t w;
    int                 frames0;
    int                 extra;
    int                 err0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    silent     = 1'b0;
    bad_parity = 1'b0;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    void'($urandom(7721));
    for (int i = 0; i < 128; i++)
      shadow[i] = 8'(i) ^ 8'hA5;              // slave power-up contents
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err0 = errors;
    repeat (20)
    begin
      step();
      check_flag("tx", tx, 1'b1);
      check_flag("cmd_rdy", cmd_rdy, 1'b1);
      check_flag("read_rdy", read_rdy, 1'b0);
    end
    end_test("idle after reset", err0);

    err0 = errors;
    issue_cmd({1'b1, 7'h15, 8'hA7});
    shadow[7'h15] = 8'hA7;
    wait_idle();
    check_byte("slave cmd byte", slv_cmd, 8'h95);
    check_byte("slave data byte", slv_data, 8'hA7);
    check_flag("slave parity error", slv_par_err, 1'b0);
    end_test("write 0x15", err0);

    err0    = errors;
    frames0 = slv_frames;
    wait_idle();
    cmd_in  = {1'b0, 7'h15, 8'h00};
    cmd_vld = 1'b1;                           // held through the whole read
    wait_read(d, e);
    cmd_vld = 1'b0;
    check_data("read_data", d, expected_read(7'h15, 1'b0));
    check_flag("read_err", e, 1'b0);
    extra = 0;
    repeat (16 * BIT_CYCLES)
    begin
      step();
      if (read_rdy)
        extra++;
    end
    check_byte("extra read_rdy pulses", 8'(extra), 8'h00);
    check_byte("slave frame count", 8'(slv_frames - frames0), 8'h01);
    end_test("read 0x15 with cmd_vld held", err0);

    err0 = errors;
    for (int n = 0; n < 40; n++)
    begin
      w = cmd_pkg::cmd_word_t'($urandom);
      a = w[14:8];
      issue_cmd(w);
      if (w[15])
        shadow[a] = w[7:0];
      else
      begin
        wait_read(d, e);
        check_data("read_data", d, expected_read(a, 1'b0));
        check_flag("read_err", e, 1'b0);
      end
    end
    wait_idle();
    end_test("random commands", err0);

    err0       = errors;
    bad_parity = 1'b1;
    issue_cmd({1'b0, 7'h15, 8'h00});
    wait_read(d, e);
    check_flag("read_err", e, 1'b1);
    bad_parity = 1'b0;
    end_test("reply with bad parity", err0);

    err0   = errors;
    silent = 1'b1;
    issue_cmd({1'b0, 7'h2C, 8'h00});
    wait_read(d, e);
    check_flag("read_err", e, 1'b1);
    check_data("read_data", d, expected_read(7'h2C, 1'b1));
    silent = 1'b0;
    issue_cmd({1'b0, 7'h2C, 8'h00});
    wait_read(d, e);
    check_flag("read_err", e, 1'b0);
    check_data("read_data", d, expected_read(7'h2C, 1'b0));
    end_test("timeout then normal read", err0);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim.f */
uart_pkg.sv
cmd_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_ctrl.sv
uart_cmd_master.sv
uart_slave_model.sv
tb_uart_cmd_master.sv
